//--- rtl/bg_fetcher.sv
// --------------------------------------------------
// background tile fetcher
// map byte, tile low, tile high, then 8 pixels
// scx fine scroll discard and bgp shading
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module bg_fetcher
	import gb_lcd_pkg::*;
(
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic line_start,
	input wire logic [7:0] ly,
	input wire logic [7:0] scx,
	input wire logic [7:0] scy,
	input wire logic [7:0] lcdc,
	input wire logic [7:0] bgp,
	output logic [12:0] render_addr,
	input wire logic [7:0] render_data,
	output logic pix_we,
	output logic [7:0] pix_index,
	output shade_t pix_shade,
	output logic line_done
);

	localparam logic [3:0] last_phase = 4'd13;
	localparam logic [3:0] first_pix_phase = 4'd6;
	localparam logic [7:0] last_pixel = 8'(`LCD_WIDTH - 1);

	logic busy;
	logic [3:0] phase; // 0..5 fetch, 6..13 pixels
	logic [4:0] tile;
	logic [2:0] skip;
	logic [7:0] x;
	logic [7:0] tile_id;
	logic [7:0] lo_byte;
	logic [7:0] shift_lo;
	logic [7:0] shift_hi;
	logic [7:0] bg_y;
	logic [4:0] map_col;
	logic data_hi;
	logic [1:0] color_idx;
	shade_t shade;

	assign bg_y = ly + scy;
	assign map_col = scx[7:3] + tile; // wraps around the 32 tile map
	assign data_hi = lcdc[4] ? 1'b0 : ~tile_id[7]; // signed ids around 9000

	// ------------------------------------------------
	// vram address per fetch step
	// ------------------------------------------------
	always_comb begin
		case (phase)
			4'd0, 4'd1: render_addr = {2'b11, lcdc[3], bg_y[7:3], map_col};
			4'd2, 4'd3: render_addr = {data_hi, tile_id, bg_y[2:0], 1'b0};
			default: render_addr = {data_hi, tile_id, bg_y[2:0], 1'b1};
		endcase
	end

	// leftmost pixel sits in bit 7
	assign color_idx = lcdc[0] ? {shift_hi[7], shift_lo[7]} : 2'b00;
	assign shade = bgp[{color_idx, 1'b0} +: 2];

	always_ff @(posedge cpu_clock) begin
		if (rst || !lcdc[7]) begin
			busy <= 1'b0;
			phase <= '0;
			tile <= '0;
			skip <= '0;
			x <= '0;
			pix_we <= 1'b0;
			line_done <= 1'b0;
		end else begin
			pix_we <= 1'b0;
			line_done <= pix_we && (pix_index == last_pixel);
			if (line_start) begin
				busy <= 1'b1;
				phase <= '0;
				tile <= '0;
				skip <= scx[2:0];
				x <= '0;
			end else if (busy) begin
				phase <= (phase == last_phase) ? 4'd0 : phase + 4'd1;
				if (phase == last_phase)
					tile <= tile + 5'd1;
				case (phase)
					4'd1: tile_id <= render_data;
					4'd3: lo_byte <= render_data;
					4'd5: begin
						shift_lo <= lo_byte;
						shift_hi <= render_data;
					end
					default: begin
						if (phase >= first_pix_phase) begin
							shift_lo <= {shift_lo[6:0], 1'b0};
							shift_hi <= {shift_hi[6:0], 1'b0};
							if (skip != 3'd0) begin
								skip <= skip - 3'd1; // fine scroll
							end else begin
								pix_we <= 1'b1;
								pix_index <= x;
								pix_shade <= shade;
								x <= x + 8'd1;
								if (x == last_pixel)
									busy <= 1'b0;
							end
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/gb_lcd.sv
// --------------------------------------------------
// lcd controller top
// registers, timing, vram, fetcher,
// line buffer and panel writer
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module gb_lcd (
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic [15:0] cpu_addr,
	input wire logic [7:0] cpu_wdata,
	input wire logic cpu_we,
	output logic [7:0] cpu_rdata,
	output logic vblank_irq,
	output logic stat_irq,
	output logic [7:0] panel_data,
	output logic panel_dc,
	output logic panel_wr
);

	localparam int index_w = $clog2(`LCD_WIDTH);

	logic [7:0] lcdc;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;
	logic [3:0] stat_en;
	logic [7:0] ly;
	logic [1:0] mode;
	logic coincidence;
	logic line_start;
	logic line_done;
	logic buf_swap;
	logic vram_we;
	logic [7:0] vram_cpu_data;
	logic [12:0] render_addr;
	logic [7:0] render_data;
	logic pix_we;
	logic [index_w-1:0] pix_index;
	logic [1:0] pix_shade;
	logic [index_w-1:0] rd_index;
	logic [1:0] rd_shade;

	lcd_regs regs0 (
		.cpu_clock, .rst, .cpu_addr, .cpu_wdata, .cpu_we, .cpu_rdata,
		.vram_cpu_data, .vram_we, .ly, .mode, .coincidence,
		.lcdc, .scy, .scx, .lyc, .bgp, .stat_en
	);

	lcd_timing timing0 (
		.cpu_clock, .rst, .lcdc_on(lcdc[7]), .lyc, .stat_en, .line_done,
		.mode, .ly, .coincidence, .line_start, .buf_swap, .vblank_irq, .stat_irq
	);

	gb_vram vram0 (
		.cpu_clock, .cpu_addr(cpu_addr[12:0]), .cpu_wdata, .vram_we, .vram_cpu_data,
		.render_addr, .render_data
	);

	bg_fetcher fetch0 (
		.cpu_clock, .rst, .line_start, .ly, .scx, .scy, .lcdc, .bgp,
		.render_addr, .render_data, .pix_we, .pix_index, .pix_shade, .line_done
	);

	line_buffer lbuf0 (
		.cpu_clock, .rst, .buf_swap, .pix_we, .pix_index, .pix_shade, .rd_index, .rd_shade
	);

	panel_writer panel0 (
		.cpu_clock, .rst, .buf_swap, .ly, .rd_index, .rd_shade,
		.panel_data, .panel_dc, .panel_wr
	);

endmodule

`default_nettype wire

//--- rtl/gb_lcd_consts.svh
// --------------------------------------------------
// lcd frame geometry and register map
// vram window, panel command bytes
// gray levels for the rgb565 panel stream
// --------------------------------------------------
`ifndef GB_LCD_CONSTS_SVH
`define GB_LCD_CONSTS_SVH

// frame geometry, one dot per clock
`define LCD_DOTS_PER_LINE 456
`define LCD_LINES 154
`define LCD_VISIBLE_LINES 144
`define LCD_WIDTH 160
`define LCD_OAM_DOTS 80 // mode 2 length

// cpu visible registers
`define LCD_ADDR_LCDC 16'hFF40
`define LCD_ADDR_STAT 16'hFF41
`define LCD_ADDR_SCY 16'hFF42
`define LCD_ADDR_SCX 16'hFF43
`define LCD_ADDR_LY 16'hFF44
`define LCD_ADDR_LYC 16'hFF45
`define LCD_ADDR_BGP 16'hFF47

`define LCD_VRAM_BASE 16'h8000
`define LCD_VRAM_LAST 16'h9FFF

// memory write start / continue
`define PANEL_CMD_FIRST 8'h2C
`define PANEL_CMD_NEXT 8'h3C

// shade 0 is white
`define GRAY5_0 5'd31
`define GRAY5_1 5'd21
`define GRAY5_2 5'd10
`define GRAY5_3 5'd0
`define GRAY6_0 6'd63
`define GRAY6_1 6'd42
`define GRAY6_2 6'd21
`define GRAY6_3 6'd0

`endif

//--- rtl/gb_lcd_pkg.sv
// --------------------------------------------------
// shared lcd types
// stat mode encoding, shade and panel pixel
// --------------------------------------------------
`default_nettype none

package gb_lcd_pkg;

	// values match the stat mode field
	typedef enum logic [1:0] {
		hblank = 2'd0,
		vblank = 2'd1,
		oam_search = 2'd2,
		transfer = 2'd3
	} lcd_mode_t;

	// gray level after bgp mapping
	typedef logic [1:0] shade_t;

	// r5 g6 b5
	typedef logic [15:0] rgb565_t;

endpackage

`default_nettype wire

//--- rtl/gb_vram.sv
// --------------------------------------------------
// 8 KiB video ram
// cpu port: sync write, async read
// render port: registered read
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module gb_vram
	import gb_lcd_pkg::*;
(
	input wire logic cpu_clock,
	input wire logic [12:0] cpu_addr,
	input wire logic [7:0] cpu_wdata,
	input wire logic vram_we,
	output logic [7:0] vram_cpu_data,
	input wire logic [12:0] render_addr,
	output logic [7:0] render_data
);

	localparam int depth = `LCD_VRAM_LAST - `LCD_VRAM_BASE + 1;

	logic [7:0] mem [depth];

	always_ff @(posedge cpu_clock) begin
		if (vram_we)
			mem[cpu_addr] <= cpu_wdata;
		render_data <= mem[render_addr]; // one cycle behind the address
	end

	assign vram_cpu_data = mem[cpu_addr];

endmodule

`default_nettype wire

//--- rtl/lcd_regs.sv
// --------------------------------------------------
// lcd register file
// lcdc, stat, scy, scx, ly, lyc, bgp
// cpu read mux, vram access blocked in mode 3
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module lcd_regs
	import gb_lcd_pkg::*;
(
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic [15:0] cpu_addr,
	input wire logic [7:0] cpu_wdata,
	input wire logic cpu_we,
	output logic [7:0] cpu_rdata,
	input wire logic [7:0] vram_cpu_data,
	output logic vram_we,
	input wire logic [7:0] ly,
	input wire logic [1:0] mode,
	input wire logic coincidence,
	output logic [7:0] lcdc,
	output logic [7:0] scy,
	output logic [7:0] scx,
	output logic [7:0] lyc,
	output logic [7:0] bgp,
	output logic [3:0] stat_en // stat bits 6..3
);

	logic in_vram;

	assign in_vram = (cpu_addr >= `LCD_VRAM_BASE) && (cpu_addr <= `LCD_VRAM_LAST);
	assign vram_we = cpu_we && in_vram && (mode != transfer); // renderer owns vram in mode 3

	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			lcdc <= '0;
			scy <= '0;
			scx <= '0;
			lyc <= '0;
			bgp <= '0;
			stat_en <= '0;
		end else if (cpu_we) begin
			case (cpu_addr)
				`LCD_ADDR_LCDC: lcdc <= cpu_wdata;
				`LCD_ADDR_STAT: stat_en <= cpu_wdata[6:3]; // low bits are status only
				`LCD_ADDR_SCY: scy <= cpu_wdata;
				`LCD_ADDR_SCX: scx <= cpu_wdata;
				`LCD_ADDR_LYC: lyc <= cpu_wdata;
				`LCD_ADDR_BGP: bgp <= cpu_wdata;
				default: ;
			endcase
		end
	end

	// read mux, unmapped reads float high
	always_comb begin
		cpu_rdata = 8'hFF;
		if (in_vram) begin
			if (mode != transfer)
				cpu_rdata = vram_cpu_data;
		end else begin
			case (cpu_addr)
				`LCD_ADDR_LCDC: cpu_rdata = lcdc;
				`LCD_ADDR_STAT: cpu_rdata = {1'b1, stat_en, coincidence, mode};
				`LCD_ADDR_SCY: cpu_rdata = scy;
				`LCD_ADDR_SCX: cpu_rdata = scx;
				`LCD_ADDR_LY: cpu_rdata = ly;
				`LCD_ADDR_LYC: cpu_rdata = lyc;
				`LCD_ADDR_BGP: cpu_rdata = bgp;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/lcd_timing.sv
// --------------------------------------------------
// dot and line counters, mode sequencing
// line start and buffer swap strobes
// vblank and stat interrupt pulses
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module lcd_timing
	import gb_lcd_pkg::*;
(
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic lcdc_on,
	input wire logic [7:0] lyc,
	input wire logic [3:0] stat_en,
	input wire logic line_done,
	output lcd_mode_t mode,
	output logic [7:0] ly,
	output logic coincidence,
	output logic line_start,
	output logic buf_swap,
	output logic vblank_irq,
	output logic stat_irq
);

	localparam logic [8:0] last_dot = 9'(`LCD_DOTS_PER_LINE - 1);
	localparam logic [8:0] oam_end = 9'(`LCD_OAM_DOTS);
	localparam logic [7:0] last_line = 8'(`LCD_LINES - 1);
	localparam logic [7:0] first_vblank = 8'(`LCD_VISIBLE_LINES);

	logic running; // low for the first cycle after power on
	logic [8:0] dot;
	logic [8:0] dot_next;
	logic [7:0] ly_next;
	lcd_mode_t mode_next;
	logic lyc_hit;

	assign coincidence = (ly == lyc);

	always_comb begin
		dot_next = dot;
		ly_next = ly;
		mode_next = mode;
		if (!running) begin
			mode_next = oam_search; // line 0 starts here
		end else if (dot == last_dot) begin
			dot_next = '0;
			ly_next = (ly == last_line) ? 8'd0 : ly + 8'd1;
			mode_next = (ly_next >= first_vblank) ? vblank : oam_search;
		end else begin
			dot_next = dot + 9'd1;
			if (mode == oam_search && dot_next == oam_end)
				mode_next = transfer;
			else if (mode == transfer && line_done)
				mode_next = hblank; // mode 3 length set by the fetcher
		end
	end

	assign lyc_hit = (ly_next != ly) && (ly_next == lyc);

	always_ff @(posedge cpu_clock) begin
		if (rst || !lcdc_on) begin
			running <= 1'b0;
			dot <= '0;
			ly <= '0;
			mode <= hblank;
			line_start <= 1'b0;
			buf_swap <= 1'b0;
			vblank_irq <= 1'b0;
			stat_irq <= 1'b0;
		end else begin
			running <= 1'b1;
			dot <= dot_next;
			ly <= ly_next;
			mode <= mode_next;
			line_start <= (mode == oam_search) && (mode_next == transfer); // dot 80
			buf_swap <= line_done;
			vblank_irq <= (mode_next == vblank) && (mode != vblank);
			stat_irq <= |(stat_en & {lyc_hit,
				(mode_next == oam_search) && (mode != oam_search),
				(mode_next == vblank) && (mode != vblank),
				(mode_next == hblank) && (mode != hblank)});
		end
	end

endmodule

`default_nettype wire

//--- rtl/line_buffer.sv
// --------------------------------------------------
// ping-pong line buffer of shades
// fetcher fills one bank, panel drains the other
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module line_buffer
	import gb_lcd_pkg::*;
(
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic buf_swap,
	input wire logic pix_we,
	input wire logic [7:0] pix_index,
	input wire shade_t pix_shade,
	input wire logic [7:0] rd_index,
	output shade_t rd_shade
);

	shade_t mem [2][`LCD_WIDTH];
	logic wr_bank;

	always_ff @(posedge cpu_clock) begin
		if (rst)
			wr_bank <= 1'b0;
		else if (buf_swap)
			wr_bank <= ~wr_bank;
	end

	always_ff @(posedge cpu_clock) begin
		if (pix_we)
			mem[wr_bank][pix_index] <= pix_shade;
		rd_shade <= mem[~wr_bank][rd_index]; // one cycle read latency
	end

endmodule

`default_nettype wire

//--- rtl/panel_writer.sv
// --------------------------------------------------
// panel writer
// command byte, then 160 rgb565 pixels
// high byte first, one byte per clock
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module panel_writer
	import gb_lcd_pkg::*;
(
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic buf_swap,
	input wire logic [7:0] ly,
	output logic [7:0] rd_index,
	input wire shade_t rd_shade,
	output logic [7:0] panel_data,
	output logic panel_dc,
	output logic panel_wr
);

	localparam logic [8:0] last_byte = 9'(2 * `LCD_WIDTH - 1);
	localparam logic [7:0] last_pixel = 8'(`LCD_WIDTH - 1);

	logic busy;
	logic cmd_cycle;
	logic [8:0] data_cnt; // bit 0 selects the low byte
	logic [7:0] cmd_byte;
	rgb565_t pix_rgb;

	always_comb begin
		case (rd_shade)
			2'd0: pix_rgb = {`GRAY5_0, `GRAY6_0, `GRAY5_0};
			2'd1: pix_rgb = {`GRAY5_1, `GRAY6_1, `GRAY5_1};
			2'd2: pix_rgb = {`GRAY5_2, `GRAY6_2, `GRAY5_2};
			default: pix_rgb = {`GRAY5_3, `GRAY6_3, `GRAY5_3};
		endcase
		if (cmd_cycle)
			panel_data = cmd_byte;
		else if (data_cnt[0])
			panel_data = pix_rgb[7:0];
		else
			panel_data = pix_rgb[15:8];
	end

	assign panel_dc = ~cmd_cycle;
	assign panel_wr = busy; // one write per cycle while busy

	always_ff @(posedge cpu_clock) begin
		if (rst) begin
			busy <= 1'b0;
			cmd_cycle <= 1'b0;
			data_cnt <= '0;
			rd_index <= '0;
		end else if (!busy) begin
			if (buf_swap) begin
				busy <= 1'b1;
				cmd_cycle <= 1'b1;
				data_cnt <= '0;
				rd_index <= '0;
				cmd_byte <= (ly == 8'd0) ? `PANEL_CMD_FIRST : `PANEL_CMD_NEXT;
			end
		end else if (cmd_cycle) begin
			cmd_cycle <= 1'b0;
		end else begin
			data_cnt <= data_cnt + 9'd1;
			// next shade must be ready by the following high byte
			if (!data_cnt[0] && rd_index != last_pixel)
				rd_index <= rd_index + 8'd1;
			if (data_cnt == last_byte)
				busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the gb_lcd testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_gb_lcd -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_gb_lcd)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1

//--- tb.f
+incdir+rtl
rtl/gb_lcd_pkg.sv
rtl/lcd_regs.sv
rtl/lcd_timing.sv
rtl/gb_vram.sv
rtl/bg_fetcher.sv
rtl/line_buffer.sv
rtl/panel_writer.sv
rtl/gb_lcd.sv
tests/gb_lcd_chk.sv
tests/gb_lcd_monitor.sv
tests/tb_gb_lcd.sv

//--- tests/gb_lcd_chk.sv
// --------------------------------------------------
// lcd protocol assertions
// panel bursts, buffer swaps, vblank line
// bound into panel_writer and lcd_timing
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module gb_lcd_chk (
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic swap,
	input wire logic busy,
	input wire logic wr_pulse,
	input wire logic irq,
	input wire logic [7:0] line
);

	int fail_count = 0; // failed assertions

	// a burst of writes only starts right after a swap
	burst_start: assert property (@(posedge cpu_clock) disable iff (rst)
		$rose(wr_pulse) |-> $past(swap))
		else begin
			$error("panel burst started without a buffer swap");
			fail_count++;
		end

	no_swap_busy: assert property (@(posedge cpu_clock) disable iff (rst)
		!(swap && busy))
		else begin
			$error("buffer swap while the panel writer is busy");
			fail_count++;
		end

	vblank_line: assert property (@(posedge cpu_clock) disable iff (rst)
		irq |-> (line == 8'd144))
		else begin
			$error("vblank interrupt outside line 144");
			fail_count++;
		end

endmodule

bind panel_writer gb_lcd_chk panel_chk0 (
	.cpu_clock, .rst, .swap(buf_swap), .busy(busy),
	.wr_pulse(panel_wr), .irq(1'b0), .line(ly)
);

bind lcd_timing gb_lcd_chk timing_chk0 (
	.cpu_clock, .rst, .swap(buf_swap), .busy(1'b0),
	.wr_pulse(1'b0), .irq(vblank_irq), .line(ly)
);

`default_nettype wire

//--- tests/gb_lcd_monitor.sv
// --------------------------------------------------
// lcd monitor
// shadows cpu writes, predicts the panel stream,
// counts lines and interrupts, keeps error counts
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module gb_lcd_monitor
	import gb_lcd_pkg::*;
(
	input wire logic cpu_clock,
	input wire logic rst,
	input wire logic [15:0] cpu_addr,
	input wire logic [7:0] cpu_wdata,
	input wire logic cpu_we,
	input wire logic vblank_irq,
	input wire logic stat_irq,
	input wire logic [7:0] panel_data,
	input wire logic panel_dc,
	input wire logic panel_wr
);

	localparam int max_reports = 20; // pixel lines printed
	localparam int idle_limit = 400; // longest tail of a line after power off

	logic [7:0] vram_copy [8192];
	logic [7:0] lcdc_s;
	logic [7:0] scx_s;
	logic [7:0] scy_s;
	logic [7:0] bgp_s;
	int line_cnt;
	int byte_cnt;
	int lines_sent;
	int vblank_cnt;
	int stat_cnt;
	int off_cycles;
	int reg_errors;
	int panel_errors;
	int pixel_errors;
	int irq_errors;

	function automatic logic [7:0] vram_at(input logic [15:0] addr);
		return vram_copy[addr[12:0]];
	endfunction

	// background rule: map byte, tile row, bit 7 leftmost, bgp shade
	function automatic rgb565_t expected_pixel(input int line, input int x);
		logic [7:0] bg_y;
		logic [7:0] px;
		logic [7:0] tile_id;
		logic [7:0] lo;
		logic [7:0] hi;
		logic [15:0] map_addr;
		logic [15:0] data_addr;
		logic [1:0] ci;
		logic [1:0] sh;
		int bit_pos;
		bg_y = 8'(line) + scy_s;
		px = 8'(x) + scx_s;
		map_addr = (lcdc_s[3] ? 16'h9C00 : 16'h9800) + 16'({bg_y[7:3], px[7:3]});
		tile_id = vram_at(map_addr);
		if (lcdc_s[4])
			data_addr = 16'h8000 + 16'({tile_id, 4'b0000});
		else
			data_addr = 16'h9000 + (16'($signed(tile_id)) << 4); // signed ids
		data_addr = data_addr + 16'({bg_y[2:0], 1'b0});
		lo = vram_at(data_addr);
		hi = vram_at(data_addr + 16'd1);
		bit_pos = 7 - int'(px[2:0]);
		ci = lcdc_s[0] ? {hi[bit_pos], lo[bit_pos]} : 2'b00;
		sh = bgp_s[2 * ci +: 2];
		case (sh)
			2'd0: return {`GRAY5_0, `GRAY6_0, `GRAY5_0};
			2'd1: return {`GRAY5_1, `GRAY6_1, `GRAY5_1};
			2'd2: return {`GRAY5_2, `GRAY6_2, `GRAY5_2};
			default: return {`GRAY5_3, `GRAY6_3, `GRAY5_3};
		endcase
	endfunction

	task automatic record_write();
		if (cpu_addr >= `LCD_VRAM_BASE && cpu_addr <= `LCD_VRAM_LAST) begin
			if (!lcdc_s[7])
				vram_copy[cpu_addr[12:0]] = cpu_wdata;
		end else begin
			case (cpu_addr)
				`LCD_ADDR_LCDC: begin
					if (cpu_wdata[7] && !lcdc_s[7]) begin
						// fresh run, panel restarts at line 0
						line_cnt = 0;
						byte_cnt = 0;
						lines_sent = 0;
						vblank_cnt = 0;
						stat_cnt = 0;
					end
					lcdc_s = cpu_wdata;
				end
				`LCD_ADDR_SCX: scx_s = cpu_wdata;
				`LCD_ADDR_SCY: scy_s = cpu_wdata;
				`LCD_ADDR_BGP: bgp_s = cpu_wdata;
				default: ;
			endcase
		end
	endtask

	task automatic check_panel_byte();
		logic [7:0] exp_cmd;
		rgb565_t exp_pix;
		logic [7:0] exp_byte;
		if (!lcdc_s[7] && off_cycles > idle_limit) begin
			panel_errors++;
			$display("[ERROR] %0t: panel write while the LCD is off", $time);
		end else if (!panel_dc) begin
			exp_cmd = (line_cnt == 0) ? `PANEL_CMD_FIRST : `PANEL_CMD_NEXT;
			if (panel_data !== exp_cmd || byte_cnt != 0) begin
				panel_errors++;
				$display("[ERROR] %0t: line %0d command %h, expected %h after %0d bytes",
					$time, line_cnt, panel_data, exp_cmd, byte_cnt);
			end
			byte_cnt = 0;
		end else begin
			exp_pix = expected_pixel(line_cnt, byte_cnt / 2);
			exp_byte = byte_cnt[0] ? exp_pix[7:0] : exp_pix[15:8]; // high byte first
			if (panel_data !== exp_byte) begin
				pixel_errors++;
				if (pixel_errors <= max_reports)
					$display("[ERROR] %0t: line %0d pixel %0d byte %0d is %h, expected %h",
						$time, line_cnt, byte_cnt / 2, byte_cnt % 2, panel_data, exp_byte);
			end
			byte_cnt++;
			if (byte_cnt == 2 * `LCD_WIDTH) begin
				byte_cnt = 0;
				lines_sent++;
				line_cnt = (line_cnt + 1) % `LCD_VISIBLE_LINES;
			end
		end
	endtask

	always @(posedge cpu_clock) begin
		if (rst) begin
			lcdc_s = '0;
			scx_s = '0;
			scy_s = '0;
			bgp_s = '0;
			off_cycles = 0;
		end else begin
			if (cpu_we)
				record_write();
			if (lcdc_s[7])
				off_cycles = 0;
			else if (off_cycles <= idle_limit)
				off_cycles++;
			if (vblank_irq)
				vblank_cnt++;
			if (stat_irq)
				stat_cnt++;
			if (panel_wr)
				check_panel_byte();
		end
	end

	task automatic compare_read(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp) begin
			reg_errors++;
			$display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// per frame: lyc match 1, mode 2 entries 144, mode 1 entries 1, mode 0 entries 144
	task automatic check_frames(input int frames, input logic [7:0] stat_en);
		int exp_stat;
		exp_stat = frames * ((stat_en[6] ? 1 : 0) + (stat_en[5] ? 144 : 0)
			+ (stat_en[4] ? 1 : 0) + (stat_en[3] ? 144 : 0));
		if (lines_sent != frames * `LCD_VISIBLE_LINES) begin
			panel_errors++;
			$display("[ERROR] %0t: %0d lines sent, expected %0d",
				$time, lines_sent, frames * `LCD_VISIBLE_LINES);
		end
		if (vblank_cnt != frames) begin
			irq_errors++;
			$display("[ERROR] %0t: %0d vblank pulses, expected %0d", $time, vblank_cnt, frames);
		end
		if (stat_cnt != exp_stat) begin
			irq_errors++;
			$display("[ERROR] %0t: %0d stat pulses, expected %0d", $time, stat_cnt, exp_stat);
		end
	endtask

endmodule

`default_nettype wire

//--- tests/tb_gb_lcd.sv
// --------------------------------------------------
// lcd controller testbench
// clock, reset, lfsr vram fill, stimulus table,
// watchdog and closing report
// --------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "gb_lcd_consts.svh"

module tb_gb_lcd;

	localparam int clk_period = 20;
	localparam int rows = 4;
	localparam int frame_cycles = `LCD_DOTS_PER_LINE * `LCD_LINES;
	localparam int watchdog_cycles = rows * 2 * frame_cycles * 3 / 2;
	localparam logic [7:0] lyc_value = 8'd77;

	// scx, scy, bgp, lcdc, stat enables
	localparam logic [39:0] test_rows [rows] = '{
		{8'h00, 8'h00, 8'hE4, 8'h91, 8'h40}, // lyc match only
		{8'h05, 8'h03, 8'h1B, 8'h81, 8'h08}, // signed tiles, mode 0 irq
		{8'hF3, 8'h9A, 8'hD2, 8'h89, 8'h30}, // map at 9c00, mode 2 and 1
		{8'h2F, 8'hFE, 8'h93, 8'h98, 8'h00}  // bg off, color forced to 0
	};

	logic cpu_clock;
	logic rst;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_wdata;
	logic cpu_we;
	logic [7:0] cpu_rdata;
	logic vblank_irq;
	logic stat_irq;
	logic [7:0] panel_data;
	logic panel_dc;
	logic panel_wr;
	logic [31:0] lfsr;

	gb_lcd dut0 (
		.cpu_clock, .rst, .cpu_addr, .cpu_wdata, .cpu_we, .cpu_rdata,
		.vblank_irq, .stat_irq, .panel_data, .panel_dc, .panel_wr
	);

	gb_lcd_monitor mon0 (
		.cpu_clock, .rst, .cpu_addr, .cpu_wdata, .cpu_we,
		.vblank_irq, .stat_irq, .panel_data, .panel_dc, .panel_wr
	);

	initial begin
		cpu_clock = 1'b0;
		forever #(clk_period / 2) cpu_clock = ~cpu_clock;
	end

	// ------------------------------------------------
	// random bytes and cpu bus
	// ------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		logic [7:0] acc;
		acc = 8'h00;
		for (int i = 0; i < 8; i++) begin
			acc = {acc[6:0], lfsr[0]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
		b = acc;
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		@(negedge cpu_clock);
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_we = 1'b1;
		@(negedge cpu_clock);
		cpu_we = 1'b0;
	endtask

	task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
		@(negedge cpu_clock);
		cpu_addr = addr;
		cpu_we = 1'b0;
		#(clk_period / 4);
		data = cpu_rdata; // mid low phase, settled
	endtask

	task automatic check_read(input logic [15:0] addr, input logic [7:0] exp, input string what);
		logic [7:0] got;
		read_reg(addr, got);
		mon0.compare_read(what, got, exp);
	endtask

	task automatic wait_mode(input logic [1:0] mode);
		logic [7:0] stat;
		stat = 8'h00;
		while (stat[1:0] != mode)
			read_reg(`LCD_ADDR_STAT, stat);
	endtask

	task automatic wait_panel_idle();
		@(negedge cpu_clock);
		while (panel_wr)
			@(negedge cpu_clock);
	endtask

	task automatic fill_vram();
		logic [7:0] b;
		for (int a = 0; a < 8192; a++) begin
			random_byte(b);
			write_reg(`LCD_VRAM_BASE + 16'(a), b);
			if (a % 512 == 0)
				check_read(`LCD_VRAM_BASE + 16'(a), b, "VRAM with the LCD off");
		end
	endtask

	// ------------------------------------------------
	// one table row
	// ------------------------------------------------
	task automatic run_row(input logic [39:0] row);
		logic [7:0] scx;
		logic [7:0] scy;
		logic [7:0] bgp;
		logic [7:0] lcdc;
		logic [7:0] stat_en;
		{scx, scy, bgp, lcdc, stat_en} = row;
		write_reg(`LCD_ADDR_LCDC, 8'h00);
		wait_panel_idle(); // a line may still be draining
		check_read(`LCD_ADDR_LY, 8'h00, "LY with the LCD off");
		fill_vram();
		write_reg(`LCD_ADDR_SCX, scx);
		write_reg(`LCD_ADDR_SCY, scy);
		write_reg(`LCD_ADDR_BGP, bgp);
		write_reg(`LCD_ADDR_LYC, lyc_value);
		write_reg(`LCD_ADDR_STAT, stat_en | 8'h07);
		write_reg(`LCD_ADDR_LCDC, lcdc & 8'h7F);
		check_read(`LCD_ADDR_SCX, scx, "SCX");
		check_read(`LCD_ADDR_SCY, scy, "SCY");
		check_read(`LCD_ADDR_BGP, bgp, "BGP");
		check_read(`LCD_ADDR_LYC, lyc_value, "LYC");
		check_read(`LCD_ADDR_LCDC, lcdc & 8'h7F, "LCDC");
		check_read(`LCD_ADDR_STAT, 8'h80 | (stat_en & 8'h78), "STAT with the LCD off");
		check_read(16'hFF46, 8'hFF, "unmapped FF46");
		check_read(16'hC000, 8'hFF, "unmapped C000");
		write_reg(`LCD_ADDR_LCDC, lcdc);
		wait_mode(2'd3);
		// line 0, no lyc match yet
		check_read(`LCD_ADDR_STAT, 8'h83 | (stat_en & 8'h78), "STAT in mode 3");
		check_read(`LCD_VRAM_BASE + 16'h0123, 8'hFF, "VRAM in mode 3");
		repeat (2) @(posedge vblank_irq);
		// line 143 is still on the panel bus after the second vblank
		repeat (2 * `LCD_DOTS_PER_LINE) @(posedge cpu_clock);
		mon0.check_frames(2, stat_en);
	endtask

	initial begin
		int total;
		int assert_fails;
		rst = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_we = 1'b0;
		lfsr = 32'h1e45b69a;
		repeat (5) @(posedge cpu_clock);
		@(negedge cpu_clock);
		rst = 1'b0;
		check_read(`LCD_ADDR_LCDC, 8'h00, "LCDC after reset");
		for (int i = 0; i < rows; i++)
			run_row(test_rows[i]);
		assert_fails = dut0.panel0.panel_chk0.fail_count
			+ dut0.timing0.timing_chk0.fail_count;
		total = mon0.reg_errors + mon0.panel_errors + mon0.pixel_errors + mon0.irq_errors
			+ assert_fails;
		$display("errors: registers %0d, panel %0d, pixels %0d, interrupts %0d, assertions %0d",
			mon0.reg_errors, mon0.panel_errors, mon0.pixel_errors, mon0.irq_errors,
			assert_fails);
		if (total == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// two frames per row plus half again for fills and register traffic
	initial begin
		repeat (watchdog_cycles) @(posedge cpu_clock);
		$display("watchdog expired, the run did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
